// ==== fm_pkg.sv ====
package fm_pkg;

    // chip geometry
    localparam int num_ch      = 3;
    localparam int num_op      = 4;
    localparam int num_slots   = num_ch * num_op;
    localparam int busy_len    = 32;  // clk_en pulses
    localparam int timer_b_div = 16;  // rounds per timer B tick

    // global register numbers
    localparam logic [7:0] reg_clka1 = 8'h24;
    localparam logic [7:0] reg_clka2 = 8'h25;
    localparam logic [7:0] reg_clkb  = 8'h26;
    localparam logic [7:0] reg_timer = 8'h27;
    localparam logic [7:0] reg_kon   = 8'h28;
    localparam logic [7:0] reg_div6  = 8'h2D;
    localparam logic [7:0] reg_div3  = 8'h2E;
    localparam logic [7:0] reg_div2  = 8'h2F;

    // operator groups, high nibble of the address
    localparam logic [3:0] grp_dt1_mul = 4'h3;
    localparam logic [3:0] grp_tl      = 4'h4;
    localparam logic [3:0] grp_ks_ar   = 4'h5;
    localparam logic [3:0] grp_am_d1r  = 4'h6;
    localparam logic [3:0] grp_d2r     = 4'h7;
    localparam logic [3:0] grp_sl_rr   = 4'h8;

    // channel groups
    localparam logic [3:0] grp_fnum_lo = 4'hA;
    localparam logic [4:0] grp_fnum_hi = 5'b1010_1;  // group A plus address bit 2
    localparam logic [3:0] grp_fb_alg  = 4'hB;

    typedef logic [1:0] ch_t;
    typedef logic [1:0] op_t;

    typedef struct packed {
        logic [3:0] group;
        op_t        op;
        ch_t        ch;
    } slot_addr_t;

    // one address byte, read as a register number or as slot fields
    typedef union packed {
        logic [7:0] code;
        slot_addr_t slot;
    } reg_addr_t;

    typedef enum logic [1:0] {
        div_6,
        div_3,
        div_2
    } div_sel_t;

endpackage

// ==== fm_mmr.sv ====
`timescale 1ns/1ps

module fm_mmr (
    input  logic             clk,
    input  logic             rst,
    input  logic             clk_en,
    input  logic [7:0]       din,
    input  logic             write,
    input  logic             a0,
    output logic [7:0]       data,
    output fm_pkg::ch_t      ch,
    output fm_pkg::op_t      op,
    output logic             up_fnum_lo,
    output logic             up_fnum_hi,
    output logic             up_fb_alg,
    output logic [5:0]       up_op,
    output logic             up_kon,
    output logic             load_a,
    output logic             load_b,
    output logic             irq_en_a,
    output logic             irq_en_b,
    output logic             clr_a,
    output logic             clr_b,
    output logic [9:0]       value_a,
    output logic [7:0]       value_b,
    output fm_pkg::div_sel_t div_sel,
    output logic             busy
);
    import fm_pkg::*;

    reg_addr_t addr;  // selected register
    logic [$clog2(busy_len)-1:0] busy_cnt;

    logic data_wr;
    logic slot_ok;  // channel 3 does not exist

    assign data_wr = write && a0;
    assign slot_ok = addr.slot.ch != 2'd3;

    // payload, follows every data write
    always_ff @(posedge clk) begin
        if (data_wr) begin
            data <= din;
            ch   <= addr.slot.ch;
            op   <= addr.slot.op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr       <= '0;
            up_fnum_lo <= 1'b0;
            up_fnum_hi <= 1'b0;
            up_fb_alg  <= 1'b0;
            up_op      <= '0;
            up_kon     <= 1'b0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_a      <= 1'b0;
            clr_b      <= 1'b0;
            value_a    <= '0;
            value_b    <= '0;
            div_sel    <= div_6;
        end else begin
            // strobes and clears last one clock
            up_fnum_lo <= 1'b0;
            up_fnum_hi <= 1'b0;
            up_fb_alg  <= 1'b0;
            up_op      <= '0;
            up_kon     <= 1'b0;
            clr_a      <= 1'b0;
            clr_b      <= 1'b0;
            if (write && !a0) begin
                addr.code <= din;
            end else if (data_wr) begin
                case (addr.code)
                    reg_clka1: value_a[9:2] <= din;
                    reg_clka2: value_a[1:0] <= din[1:0];
                    reg_clkb:  value_b      <= din;
                    reg_timer: begin
                        {clr_b, clr_a}       <= din[5:4];
                        {irq_en_b, irq_en_a} <= din[3:2];
                        {load_b, load_a}     <= din[1:0];
                    end
                    reg_kon:  up_kon  <= 1'b1;
                    reg_div6: div_sel <= div_6;
                    reg_div3: div_sel <= div_3;
                    reg_div2: div_sel <= div_2;
                    default: ;
                endcase
                if (slot_ok) begin
                    case (addr.slot.group)
                        grp_dt1_mul: up_op <= 6'b000001;
                        grp_tl:      up_op <= 6'b000010;
                        grp_ks_ar:   up_op <= 6'b000100;
                        grp_am_d1r:  up_op <= 6'b001000;
                        grp_d2r:     up_op <= 6'b010000;
                        grp_sl_rr:   up_op <= 6'b100000;
                        default: ;
                    endcase
                    // A0-A2 low fnum, A4-A6 high fnum, B0-B2 fb and alg
                    up_fnum_lo <= addr.slot.group == grp_fnum_lo && addr.slot.op == 2'd0;
                    up_fnum_hi <= {addr.slot.group, addr.slot.op[0]} == grp_fnum_hi
                                  && !addr.slot.op[1];
                    up_fb_alg  <= addr.slot.group == grp_fb_alg && addr.slot.op == 2'd0;
                end
            end
        end
    end

    // busy restarts on every data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (clk_en && busy) begin
            busy_cnt <= busy_cnt + 1'b1;
            if (busy_cnt == $bits(busy_cnt)'(busy_len - 1))
                busy <= 1'b0;  // 32nd pulse
        end
    end

endmodule

// ==== fm_clk_div.sv ====
`timescale 1ns/1ps

module fm_clk_div (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  fm_pkg::div_sel_t div_sel,
    output logic             clk_en
);
    import fm_pkg::*;

    div_sel_t   last_sel;
    logic [2:0] cnt;
    logic [2:0] div_n;

    always_comb begin
        case (div_sel)
            div_3:   div_n = 3'd3;
            div_2:   div_n = 3'd2;
            default: div_n = 3'd6;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            clk_en   <= 1'b0;
            last_sel <= div_6;
        end else begin
            clk_en   <= 1'b0;
            last_sel <= div_sel;
            if (div_sel != last_sel) begin
                cnt <= '0;  // new ratio, start over
            end else if (cen) begin
                if (cnt == div_n - 3'd1) begin
                    cnt    <= '0;
                    clk_en <= 1'b1;
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

endmodule

// ==== fm_timers.sv ====
`timescale 1ns/1ps

module fm_timers (
    input  logic       clk,
    input  logic       rst,
    input  logic       round_tick,
    input  logic       load_a,
    input  logic       load_b,
    input  logic       irq_en_a,
    input  logic       irq_en_b,
    input  logic       clr_a,
    input  logic       clr_b,
    input  logic [9:0] value_a,
    input  logic [7:0] value_b,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);
    import fm_pkg::*;

    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [$clog2(timer_b_div)-1:0] pre_b;
    logic ovf_a;
    logic ovf_b;
    logic tick_b;

    assign tick_b = round_tick && pre_b == $bits(pre_b)'(timer_b_div - 1);
    assign irq_n  = !(flag_a || flag_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a  <= '0;
            cnt_b  <= '0;
            pre_b  <= '0;
            ovf_a  <= 1'b0;
            ovf_b  <= 1'b0;
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            ovf_a <= 1'b0;
            ovf_b <= 1'b0;
            // a stopped timer sits at its start value
            if (!load_a) begin
                cnt_a <= value_a;
            end else if (round_tick) begin
                ovf_a <= &cnt_a;
                cnt_a <= &cnt_a ? value_a : cnt_a + 10'd1;
            end
            if (!load_b) begin
                cnt_b <= value_b;
                pre_b <= '0;
            end else if (round_tick) begin
                pre_b <= pre_b + 1'b1;
                if (tick_b) begin
                    ovf_b <= &cnt_b;
                    cnt_b <= &cnt_b ? value_b : cnt_b + 8'd1;
                end
            end
            // sticky until cleared
            if (clr_a)
                flag_a <= 1'b0;
            else if (ovf_a && irq_en_a)
                flag_a <= 1'b1;
            if (clr_b)
                flag_b <= 1'b0;
            else if (ovf_b && irq_en_b)
                flag_b <= 1'b1;
        end
    end

endmodule

// ==== fm_ch_regs.sv ====
`timescale 1ns/1ps

module fm_ch_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  data,
    input  fm_pkg::ch_t ch,
    input  fm_pkg::ch_t cur_ch,
    input  logic        up_fnum_lo,
    input  logic        up_fnum_hi,
    input  logic        up_fb_alg,
    output logic [10:0] fnum,
    output logic [2:0]  block,
    output logic [2:0]  fb,
    output logic [2:0]  alg
);
    import fm_pkg::*;

    logic [10:0] fnum_mem [num_ch];
    logic [2:0]  block_mem [num_ch];
    logic [2:0]  fb_mem [num_ch];
    logic [2:0]  alg_mem [num_ch];
    logic [5:0]  fnum_latch;  // block and fnum[10:8], one for all channels

    always_ff @(posedge clk) begin
        if (rst) begin
            fnum_latch <= '0;
            for (int i = 0; i < num_ch; i++) begin
                fnum_mem[i]  <= '0;
                block_mem[i] <= '0;
                fb_mem[i]    <= '0;
                alg_mem[i]   <= '0;
            end
        end else begin
            if (up_fnum_hi)
                fnum_latch <= data[5:0];
            if (up_fnum_lo)
                {block_mem[ch], fnum_mem[ch]} <= {fnum_latch, data};
            if (up_fb_alg) begin
                fb_mem[ch]  <= data[5:3];
                alg_mem[ch] <= data[2:0];
            end
        end
    end

    assign fnum  = fnum_mem[cur_ch];
    assign block = block_mem[cur_ch];
    assign fb    = fb_mem[cur_ch];
    assign alg   = alg_mem[cur_ch];

endmodule

// ==== fm_op_regs.sv ====
`timescale 1ns/1ps

module fm_op_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  data,
    input  fm_pkg::ch_t ch,
    input  fm_pkg::op_t op,
    input  fm_pkg::ch_t cur_ch,
    input  fm_pkg::op_t cur_op,
    input  logic [5:0]  up_op,
    output logic [2:0]  dt1,
    output logic [3:0]  mul,
    output logic [6:0]  tl,
    output logic [1:0]  ks,
    output logic [4:0]  ar,
    output logic        am_en,
    output logic [4:0]  d1r,
    output logic [4:0]  d2r,
    output logic [3:0]  sl,
    output logic [3:0]  rr
);
    import fm_pkg::*;

    // one entry per channel and operator
    logic [6:0] dt1_mul_mem [num_ch][num_op];
    logic [6:0] tl_mem [num_ch][num_op];
    logic [6:0] ks_ar_mem [num_ch][num_op];
    logic [5:0] am_d1r_mem [num_ch][num_op];
    logic [4:0] d2r_mem [num_ch][num_op];
    logic [7:0] sl_rr_mem [num_ch][num_op];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < num_ch; c++) begin
                for (int o = 0; o < num_op; o++) begin
                    dt1_mul_mem[c][o] <= '0;
                    tl_mem[c][o]      <= '0;
                    ks_ar_mem[c][o]   <= '0;
                    am_d1r_mem[c][o]  <= '0;
                    d2r_mem[c][o]     <= '0;
                    sl_rr_mem[c][o]   <= '0;
                end
            end
        end else begin
            if (up_op[0]) dt1_mul_mem[ch][op] <= data[6:0];
            if (up_op[1]) tl_mem[ch][op]      <= data[6:0];
            if (up_op[2]) ks_ar_mem[ch][op]   <= {data[7:6], data[4:0]};
            if (up_op[3]) am_d1r_mem[ch][op]  <= {data[7], data[4:0]};
            if (up_op[4]) d2r_mem[ch][op]     <= data[4:0];
            if (up_op[5]) sl_rr_mem[ch][op]   <= data;
        end
    end

    // read out at the current slot
    assign {dt1, mul}  = dt1_mul_mem[cur_ch][cur_op];
    assign tl          = tl_mem[cur_ch][cur_op];
    assign {ks, ar}    = ks_ar_mem[cur_ch][cur_op];
    assign {am_en, d1r} = am_d1r_mem[cur_ch][cur_op];
    assign d2r         = d2r_mem[cur_ch][cur_op];
    assign {sl, rr}    = sl_rr_mem[cur_ch][cur_op];

endmodule

// ==== fm_slot_seq.sv ====
`timescale 1ns/1ps

module fm_slot_seq (
    input  logic        clk,
    input  logic        rst,
    input  logic        clk_en,
    input  logic        up_kon,
    input  logic [7:0]  data,
    output fm_pkg::ch_t cur_ch,
    output fm_pkg::op_t cur_op,
    output logic        keyon,
    output logic        round_tick
);
    import fm_pkg::*;

    logic [num_op-1:0] kon [num_ch];  // bit 0 is op 0
    ch_t kon_ch;
    logic last_slot;

    assign kon_ch    = ch_t'(data[1:0]);
    assign last_slot = cur_ch == ch_t'(num_ch - 1) && cur_op == op_t'(num_op - 1);
    assign keyon     = kon[cur_ch][cur_op];

    // channels step fastest, then operators
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_ch     <= '0;
            cur_op     <= '0;
            round_tick <= 1'b0;
        end else begin
            round_tick <= clk_en && last_slot;
            if (clk_en) begin
                if (cur_ch == ch_t'(num_ch - 1)) begin
                    cur_ch <= '0;
                    cur_op <= cur_op + 2'd1;  // wraps after op 3
                end else begin
                    cur_ch <= cur_ch + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_ch; i++)
                kon[i] <= '0;
        end else if (up_kon && kon_ch != 2'd3) begin
            kon[kon_ch] <= data[7:4];
        end
    end

endmodule

// ==== fm_top.sv ====
`timescale 1ns/1ps

module fm_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  din,
    input  logic        write,
    input  logic        a0,
    output logic        clk_en,
    output logic [7:0]  status,
    output logic        irq_n,
    output fm_pkg::ch_t cur_ch,
    output fm_pkg::op_t cur_op,
    output logic        keyon,
    output logic [10:0] fnum,
    output logic [2:0]  block,
    output logic [2:0]  fb,
    output logic [2:0]  alg,
    output logic [2:0]  dt1,
    output logic [3:0]  mul,
    output logic [6:0]  tl,
    output logic [1:0]  ks,
    output logic [4:0]  ar,
    output logic        am_en,
    output logic [4:0]  d1r,
    output logic [4:0]  d2r,
    output logic [3:0]  sl,
    output logic [3:0]  rr
);
    import fm_pkg::*;

    logic [7:0] data;
    ch_t        ch;
    op_t        op;
    logic       up_fnum_lo, up_fnum_hi, up_fb_alg, up_kon;
    logic [5:0] up_op;
    logic       load_a, load_b, irq_en_a, irq_en_b, clr_a, clr_b;
    logic [9:0] value_a;
    logic [7:0] value_b;
    div_sel_t   div_sel;
    logic       busy, flag_a, flag_b, round_tick;

    assign status = {busy, 5'd0, flag_b, flag_a};

    fm_mmr mmr_i (
        .clk(clk), .rst(rst), .clk_en(clk_en),
        .din(din), .write(write), .a0(a0),
        .data(data), .ch(ch), .op(op),
        .up_fnum_lo(up_fnum_lo), .up_fnum_hi(up_fnum_hi), .up_fb_alg(up_fb_alg),
        .up_op(up_op), .up_kon(up_kon),
        .load_a(load_a), .load_b(load_b), .irq_en_a(irq_en_a), .irq_en_b(irq_en_b),
        .clr_a(clr_a), .clr_b(clr_b), .value_a(value_a), .value_b(value_b),
        .div_sel(div_sel), .busy(busy)
    );

    fm_clk_div clk_div_i (
        .clk(clk), .rst(rst), .cen(cen), .div_sel(div_sel), .clk_en(clk_en)
    );

    fm_timers timers_i (
        .clk(clk), .rst(rst), .round_tick(round_tick),
        .load_a(load_a), .load_b(load_b), .irq_en_a(irq_en_a), .irq_en_b(irq_en_b),
        .clr_a(clr_a), .clr_b(clr_b), .value_a(value_a), .value_b(value_b),
        .flag_a(flag_a), .flag_b(flag_b), .irq_n(irq_n)
    );

    fm_ch_regs ch_regs_i (
        .clk(clk), .rst(rst), .data(data), .ch(ch), .cur_ch(cur_ch),
        .up_fnum_lo(up_fnum_lo), .up_fnum_hi(up_fnum_hi), .up_fb_alg(up_fb_alg),
        .fnum(fnum), .block(block), .fb(fb), .alg(alg)
    );

    fm_op_regs op_regs_i (
        .clk(clk), .rst(rst), .data(data), .ch(ch), .op(op),
        .cur_ch(cur_ch), .cur_op(cur_op), .up_op(up_op),
        .dt1(dt1), .mul(mul), .tl(tl), .ks(ks), .ar(ar), .am_en(am_en),
        .d1r(d1r), .d2r(d2r), .sl(sl), .rr(rr)
    );

    fm_slot_seq slot_seq_i (
        .clk(clk), .rst(rst), .clk_en(clk_en), .up_kon(up_kon), .data(data),
        .cur_ch(cur_ch), .cur_op(cur_op), .keyon(keyon), .round_tick(round_tick)
    );

endmodule

// ==== fm_mmr_chk.sv ====
`timescale 1ns/1ps

module fm_mmr_chk (
    input logic       clk,
    input logic       rst,
    input logic       clk_en,
    input logic       up_fnum_lo,
    input logic       up_fnum_hi,
    input logic       up_fb_alg,
    input logic [5:0] up_op,
    input logic       up_kon,
    input logic       clr_a,
    input logic       clr_b,
    input logic       busy
);
    int fail_cnt = 0;  // failed assertions so far

    // one register file at a time
    strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({up_fnum_lo, up_fnum_hi, up_fb_alg, up_op, up_kon}))
    else begin
        fail_cnt++;
        $error("more than one update strobe high");
    end

    clr_a_pulse: assert property (@(posedge clk) disable iff (rst) clr_a |=> !clr_a)
    else begin
        fail_cnt++;
        $error("clr_a held longer than one cycle");
    end

    clr_b_pulse: assert property (@(posedge clk) disable iff (rst) clr_b |=> !clr_b)
    else begin
        fail_cnt++;
        $error("clr_b held longer than one cycle");
    end

    // busy counts clk_en pulses so it only drops after one
    busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(clk_en))
    else begin
        fail_cnt++;
        $error("busy fell without a clk_en pulse");
    end

endmodule

bind fm_mmr fm_mmr_chk chk_i (.*);

// ==== tb_fm.sv ====
`timescale 1ns/1ps

module tb_fm;
    import fm_pkg::*;

    localparam int clk_period = 20;

    typedef enum int {k_write, k_check, k_count, k_irq} kind_t;
    typedef enum int {
        sig_dt1, sig_mul, sig_tl, sig_ks, sig_ar, sig_am_en, sig_d1r, sig_d2r,
        sig_sl, sig_rr, sig_fnum, sig_block, sig_fb, sig_alg, sig_keyon,
        sig_busy, sig_flag_a, sig_status, sig_irq_n
    } sig_t;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  din;
    logic        write;
    logic        a0;
    logic        clk_en;
    logic [7:0]  status;
    logic        irq_n;
    ch_t         cur_ch;
    op_t         cur_op;
    logic        keyon;
    logic [10:0] fnum;
    logic [2:0]  block;
    logic [2:0]  fb;
    logic [2:0]  alg;
    logic [2:0]  dt1;
    logic [3:0]  mul;
    logic [6:0]  tl;
    logic [1:0]  ks;
    logic [4:0]  ar;
    logic        am_en;
    logic [4:0]  d1r;
    logic [4:0]  d2r;
    logic [3:0]  sl;
    logic [3:0]  rr;

    // step table of kind, address, data and expected value
    kind_t       kind_q[$];
    logic [7:0]  addr_q[$];
    int          data_q[$];
    int          exp_q[$];
    logic [16:0] lfsr;

    // slot seen at the last falling edge
    ch_t         prev_ch;
    op_t         prev_op;
    logic        prev_en;
    logic        slot_seen = 1'b0;

    fm_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // x^17 + x^14 + 1
    function automatic logic next_bit();
        logic fb_bit;
        fb_bit = lfsr[16] ^ lfsr[13];
        lfsr = {lfsr[15:0], fb_bit};
        return fb_bit;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++)
            b = {b[6:0], next_bit()};
        return b;
    endfunction

    function automatic int read_sig(sig_t s);
        case (s)
            sig_dt1:    return int'(dt1);
            sig_mul:    return int'(mul);
            sig_tl:     return int'(tl);
            sig_ks:     return int'(ks);
            sig_ar:     return int'(ar);
            sig_am_en:  return int'(am_en);
            sig_d1r:    return int'(d1r);
            sig_d2r:    return int'(d2r);
            sig_sl:     return int'(sl);
            sig_rr:     return int'(rr);
            sig_fnum:   return int'(fnum);
            sig_block:  return int'(block);
            sig_fb:     return int'(fb);
            sig_alg:    return int'(alg);
            sig_keyon:  return int'(keyon);
            sig_busy:   return int'(status[7]);
            sig_flag_a: return int'(status[0]);
            sig_status: return int'(status);
            default:    return int'(irq_n);
        endcase
    endfunction

    task automatic check(string name, int got, int exp, int tol);
        if (got < exp - tol || got > exp + tol) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_step(kind_t k, logic [7:0] a, int d, int e);
        kind_q.push_back(k);
        addr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(e);
    endtask

    task automatic add_write(logic [7:0] a, int d);
        add_step(k_write, a, d, 0);
    endtask

    // channel 3 means sample now without waiting for a slot
    task automatic add_check(int c, int o, sig_t s, int e);
        reg_addr_t ra;
        ra.slot.group = 4'h0;
        ra.slot.op    = op_t'(o);
        ra.slot.ch    = ch_t'(c);
        add_step(k_check, ra.code, s, e);
    endtask

    task automatic build_table();
        int         pair_ch [4] = '{0, 1, 2, 0};
        int         pair_op [4] = '{0, 2, 3, 3};
        logic [7:0] b [4][6];
        logic [7:0] hi;
        logic [7:0] lo;
        int         ta;
        reg_addr_t  ra;
        add_step(k_count, 8'd1, 0, 6);  // divide 6 out of reset
        for (int p = 0; p < 4; p++) begin
            for (int g = 0; g < 6; g++) begin
                b[p][g]       = rand_byte();
                ra.slot.group = grp_dt1_mul + 4'(g);
                ra.slot.op    = op_t'(pair_op[p]);
                ra.slot.ch    = ch_t'(pair_ch[p]);
                add_write(ra.code, int'(b[p][g]));
            end
        end
        for (int p = 0; p < 4; p++) begin
            add_check(pair_ch[p], pair_op[p], sig_dt1, int'(b[p][0][6:4]));
            add_check(pair_ch[p], pair_op[p], sig_mul, int'(b[p][0][3:0]));
            add_check(pair_ch[p], pair_op[p], sig_tl, int'(b[p][1][6:0]));
            add_check(pair_ch[p], pair_op[p], sig_ks, int'(b[p][2][7:6]));
            add_check(pair_ch[p], pair_op[p], sig_ar, int'(b[p][2][4:0]));
            add_check(pair_ch[p], pair_op[p], sig_am_en, int'(b[p][3][7]));
            add_check(pair_ch[p], pair_op[p], sig_d1r, int'(b[p][3][4:0]));
            add_check(pair_ch[p], pair_op[p], sig_d2r, int'(b[p][4][4:0]));
            add_check(pair_ch[p], pair_op[p], sig_sl, int'(b[p][5][7:4]));
            add_check(pair_ch[p], pair_op[p], sig_rr, int'(b[p][5][3:0]));
        end
        // frequency goes through the shared high latch
        hi = 8'h2D;
        lo = 8'h9C;
        add_write(8'hA4, int'(hi));
        add_write(8'hA1, int'(lo));
        add_check(1, 0, sig_fnum, int'({hi[2:0], lo}));
        add_check(1, 0, sig_block, int'(hi[5:3]));
        add_check(0, 0, sig_fnum, 0);
        add_check(2, 0, sig_block, 0);
        add_write(8'hB2, 8'h2B);  // fb 5, alg 3
        add_check(2, 0, sig_fb, 5);
        add_check(2, 0, sig_alg, 3);
        add_check(1, 0, sig_fb, 0);
        add_write(reg_kon, 8'h51);  // ch 1, ops 0 and 2
        for (int o = 0; o < num_op; o++)
            add_check(1, o, sig_keyon, (5 >> o) & 1);
        add_check(0, 0, sig_keyon, 0);
        add_check(2, 2, sig_keyon, 0);
        add_write(reg_kon, 8'hF3);  // no such channel
        for (int o = 0; o < num_op; o++)
            add_check(1, o, sig_keyon, (5 >> o) & 1);
        add_check(0, 1, sig_keyon, 0);
        add_check(2, 3, sig_keyon, 0);
        add_write(reg_clkb, 8'h00);
        add_check(3, 0, sig_busy, 1);
        add_step(k_count, 8'd0, 1, busy_len);
        ta = 1020;
        add_write(reg_clka1, ta >> 2);
        add_write(reg_clka2, ta & 3);
        add_write(reg_timer, 8'h05);  // load and irq enable for A
        add_step(k_irq, 8'd0, num_slots, (1024 - ta) * num_slots);
        add_check(3, 0, sig_status, 8'h01);  // busy has run out, timer B idle
        add_check(3, 0, sig_irq_n, 0);
        add_write(reg_timer, 8'h10);  // clear A and stop it
        add_check(3, 0, sig_flag_a, 0);
        add_check(3, 0, sig_irq_n, 1);
        add_write(reg_div3, 8'h00);
        add_step(k_count, 8'd1, 0, 3);
        add_write(reg_div2, 8'h00);
        add_step(k_count, 8'd1, 0, 2);
    endtask

    // address cycle then data cycle of one clock each
    task automatic write_reg(logic [7:0] a, logic [7:0] d);
        @(posedge clk);
        write <= 1'b1;
        a0    <= 1'b0;
        din   <= a;
        @(posedge clk);
        a0  <= 1'b1;
        din <= d;
        @(posedge clk);
        write <= 1'b0;
        @(posedge clk);  // register files take it here
    endtask

    task automatic do_check(logic [7:0] a, sig_t s, int e);
        reg_addr_t ra;
        string     nm;
        ra.code = a;
        nm = s.name();
        @(negedge clk);
        if (ra.slot.ch != 2'd3) begin
            while (cur_ch != ra.slot.ch || cur_op != ra.slot.op)
                @(negedge clk);
        end
        check(nm.substr(4, nm.len() - 1), read_sig(s), e, 0);
    endtask

    task automatic count_busy(int e, int tol);
        int n;
        n = 0;
        @(negedge clk);
        while (status[7]) begin
            if (clk_en)
                n++;
            @(negedge clk);
        end
        check("clk_en pulses while busy", n, e, tol);
    endtask

    task automatic measure_spacing(int e);
        int n;
        n = 0;
        @(negedge clk);
        while (!clk_en)
            @(negedge clk);
        do begin
            n++;
            @(negedge clk);
        end while (!clk_en);
        check("clk_en spacing", n, e, 0);
    endtask

    task automatic count_to_irq(int e, int tol);
        int n;
        n = 0;
        @(negedge clk);
        while (irq_n) begin
            if (clk_en)
                n++;
            @(negedge clk);
        end
        check("clk_en pulses to irq_n", n, e, tol);
    endtask

    // channels step fastest, one slot per clk_en
    task automatic check_slot_order();
        int exp_ch;
        int exp_op;
        exp_ch = int'(prev_ch);
        exp_op = int'(prev_op);
        if (prev_en) begin
            exp_ch = (exp_ch + 1) % num_ch;
            if (exp_ch == 0)
                exp_op = (exp_op + 1) % num_op;
        end
        check("cur_ch", int'(cur_ch), exp_ch, 0);
        check("cur_op", int'(cur_op), exp_op, 0);
    endtask

    initial begin
        rst   = 1'b1;
        cen   = 1'b1;
        din   = 8'h00;
        write = 1'b0;
        a0    = 1'b0;
        lfsr  = 17'd98352;
        build_table();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < kind_q.size(); i++) begin
            case (kind_q[i])
                k_write: write_reg(addr_q[i], 8'(data_q[i]));
                k_check: do_check(addr_q[i], sig_t'(data_q[i]), exp_q[i]);
                k_count: begin
                    if (addr_q[i] == 8'd0)
                        count_busy(exp_q[i], data_q[i]);
                    else
                        measure_spacing(exp_q[i]);
                end
                default: count_to_irq(exp_q[i], data_q[i]);
            endcase
        end
        if (dut_i.mmr_i.chk_i.fail_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "assertion failure in the control module");
        end
    end

    always @(negedge clk) begin
        if (slot_seen)
            check_slot_order();
        slot_seen = !rst;
        prev_ch   = cur_ch;
        prev_op   = cur_op;
        prev_en   = clk_en;
    end

    always @(negedge clk) begin
        if (dut_i.mmr_i.chk_i.fail_cnt != 0) begin
            $display("An assertion on the control module failed at %0t ns", $time);
            $display("Testbench failed");
            $fatal(1, "assertion failure");
        end
    end

    // 40 rounds at divide 6 per table step
    initial begin
        longint limit;
        #1;
        limit = longint'(kind_q.size()) * longint'(40 * num_slots * 6 * clk_period);
        #(limit);
        $display("Timeout: the test did not finish within %0d ns", limit);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== list.f ====
fm_pkg.sv
fm_mmr.sv
fm_clk_div.sv
fm_timers.sv
fm_ch_regs.sv
fm_op_regs.sv
fm_slot_seq.sv
fm_top.sv
fm_mmr_chk.sv
tb_fm.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --top-module tb_fm -f list.f

run: compile
	@out=$$(./obj_dir/Vtb_fm +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
